// ==== pixelGen_settings.svh ====
//------------------------------
// Pixel generator settings
// Coordinate widths, color depth and FIFO depths
//------------------------------
`ifndef PIXEL_GEN_SETTINGS_SVH
`define PIXEL_GEN_SETTINGS_SVH

// Display coordinates and sizes
`define PIXEL_HWIDTH 11
`define PIXEL_VWIDTH 11

// ARGB4444 dot, alpha in the top nibble
`define PIXEL_COLOR_DEPTH 16

// Per-layer dot FIFO
`define LAYER_FIFO_DEPTH 16

// Composed RGB pixel FIFO
`define OUT_FIFO_DEPTH 16

`endif

// ==== pixelGenPkg.sv ====
//------------------------------
// Pixel generator types
// Dot, pixel, rectangle and control state
//------------------------------
`include "pixelGen_settings.svh"

package pixelGenPkg;

	// One color channel, four per dot
	localparam int cChWidth = `PIXEL_COLOR_DEPTH / 4;
	// RGB without alpha, 12 bits
	localparam int cRgbWidth = `PIXEL_COLOR_DEPTH - cChWidth;

	// Layer dot, ARGB plus frame mark
	typedef struct packed {
		logic [cChWidth-1:0] alpha;
		logic [cChWidth-1:0] red;
		logic [cChWidth-1:0] green;
		logic [cChWidth-1:0] blue;
		logic                frameStart;
	} dotT;

	// Output pixel, alpha removed
	typedef struct packed {
		logic [cChWidth-1:0] red;
		logic [cChWidth-1:0] green;
		logic [cChWidth-1:0] blue;
		logic                frameStart;
	} pixelT;

	// Inclusive bounds and ARGB fill
	typedef struct packed {
		logic [`PIXEL_HWIDTH-1:0]      xStart;
		logic [`PIXEL_HWIDTH-1:0]      xEnd;
		logic [`PIXEL_VWIDTH-1:0]      yStart;
		logic [`PIXEL_VWIDTH-1:0]      yEnd;
		logic [`PIXEL_COLOR_DEPTH-1:0] color;
	} rectT;

	typedef enum logic [1:0] {IDLE, LOAD, RUN} ctrlStateT;

endpackage

// ==== pixelFifo.sv ====
//------------------------------
// Synchronous FWFT FIFO
// Head word always visible on oData
//------------------------------
`timescale 1ns/1ns

module pixelFifo #(
	parameter int pWidth = 16,
	parameter int pDepth = 16
)(
	input  logic              iClk,
	input  logic              reset,
	input  logic              iPush,
	input  logic              iPop,
	input  logic [pWidth-1:0] iData,
	output logic [pWidth-1:0] oData,
	output logic              oFull,
	output logic              oEmp
);

	localparam int cPtrWidth = (pDepth > 1) ? $clog2(pDepth) : 1;
	localparam int cCntWidth = $clog2(pDepth + 1);

	logic [pWidth-1:0]    fifoMem [pDepth];
	logic [cPtrWidth-1:0] wrPtr;
	logic [cPtrWidth-1:0] rdPtr;
	logic [cCntWidth-1:0] level;

	// Storage, written at the tail
	always_ff @(posedge iClk)
	begin
		if (iPush)
		begin
			fifoMem[wrPtr] <= iData;
		end
	end

	// Pointers wrap at the last slot
	always_ff @(posedge iClk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end
		else
		begin
			if (iPush)
				wrPtr <= (wrPtr == cPtrWidth'(pDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (iPop)
				rdPtr <= (rdPtr == cPtrWidth'(pDepth - 1)) ? '0 : rdPtr + 1'b1;
			// Fill level
			unique case ({iPush, iPop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	assign oData = fifoMem[rdPtr];
	assign oFull = (level == cCntWidth'(pDepth));
	assign oEmp  = (level == '0);

	// Callers must respect the level flags
	aPushFull : assert property (@(posedge iClk) disable iff (reset) iPush |-> !oFull)
		else $error("Fail %0t: push into full FIFO", $time);
	aPopEmpty : assert property (@(posedge iClk) disable iff (reset) iPop |-> !oEmp)
		else $error("Fail %0t: pop from empty FIFO", $time);

endmodule

// ==== drawPosition.sv ====
//------------------------------
// Raster position counter
// Left to right, top to bottom, origin marks frame
//------------------------------
`timescale 1ns/1ns
`include "pixelGen_settings.svh"

module drawPosition (
	input  logic                     iClk,
	input  logic                     reset,
	input  logic                     iStep,
	input  logic [`PIXEL_HWIDTH-1:0] iLastCol,
	input  logic [`PIXEL_VWIDTH-1:0] iLastRow,
	output logic [`PIXEL_HWIDTH-1:0] oHpos,
	output logic [`PIXEL_VWIDTH-1:0] oVpos,
	output logic                     oFrameStart
);

	logic [`PIXEL_HWIDTH-1:0] hPos;
	logic [`PIXEL_VWIDTH-1:0] vPos;

	// Column inner, row outer
	always_ff @(posedge iClk)
	begin
		if (reset)
		begin
			hPos <= '0;
			vPos <= '0;
		end
		else if (iStep)
		begin
			if (hPos == iLastCol)
			begin
				hPos <= '0;
				// End of line, next row or wrap to top
				if (vPos == iLastRow)
					vPos <= '0;
				else
					vPos <= vPos + 1'b1;
			end
			else
			begin
				hPos <= hPos + 1'b1;
			end
		end
	end

	assign oHpos       = hPos;
	assign oVpos       = vPos;
	// First pixel of the frame
	assign oFrameStart = (hPos == '0) && (vPos == '0);

	// Registered size at the top bounds every stepped position
	aInBounds : assert property (@(posedge iClk) disable iff (reset)
		iStep |-> (hPos <= iLastCol) && (vPos <= iLastRow))
		else $error("Fail %0t: position outside display", $time);

endmodule

// ==== squareLayer.sv ====
//------------------------------
// Square drawing layer
// Rectangle hit test, one dot per step into a FIFO
//------------------------------
`timescale 1ns/1ns
`include "pixelGen_settings.svh"

module squareLayer
	import pixelGenPkg::*;
(
	input  logic                     iClk,
	input  logic                     reset,
	input  rectT                     iRect,
	input  logic [`PIXEL_HWIDTH-1:0] iHpos,
	input  logic [`PIXEL_VWIDTH-1:0] iVpos,
	input  logic                     iFrameStart,
	input  logic                     iStep,
	input  logic                     iPop,
	output dotT                      oDot,
	output logic                     oFull,
	output logic                     oEmp
);

	logic hitX;
	logic hitY;
	logic hit;
	dotT  pushDot;

	//------------------------------
	// Hit test
	//------------------------------
	// Bounds are inclusive on both ends
	assign hitX = (iHpos >= iRect.xStart) && (iHpos <= iRect.xEnd);
	assign hitY = (iVpos >= iRect.yStart) && (iVpos <= iRect.yEnd);
	assign hit  = hitX && hitY;

	// Miss gives a fully transparent dot
	always_comb
	begin
		if (hit)
			{pushDot.alpha, pushDot.red, pushDot.green, pushDot.blue} = iRect.color;
		else
			{pushDot.alpha, pushDot.red, pushDot.green, pushDot.blue} = '0;
		pushDot.frameStart = iFrameStart;
	end

	//------------------------------
	// Dot FIFO
	//------------------------------
	// Pushed with the same step that advances the raster
	pixelFifo #(
		.pWidth ($bits(dotT)),
		.pDepth (`LAYER_FIFO_DEPTH)
	) dotFifo_inst (
		.iClk  (iClk),
		.reset (reset),
		.iPush (iStep),
		.iPop  (iPop),
		.iData (pushDot),
		.oData (oDot),
		.oFull (oFull),
		.oEmp  (oEmp)
	);

endmodule

// ==== layerMerge.sv ====
//------------------------------
// Layer merge
// Painter's order composition to RGB, output FIFO and register
//------------------------------
`timescale 1ns/1ns
`include "pixelGen_settings.svh"

module layerMerge
	import pixelGenPkg::*;
(
	input  logic  iClk,
	input  logic  reset,
	input  dotT   iBack,
	input  dotT   iSprite,
	input  logic  iMerge,
	input  logic  iPop,
	output pixelT oPixel,
	output logic  oVd,
	output logic  oFull,
	output logic  oEmp
);

	logic [cRgbWidth-1:0] mergeRgb;
	pixelT                pushPixel;
	pixelT                headPixel;

	//------------------------------
	// Composition
	//------------------------------
	// Sprite on top, then background, else black
	always_comb
	begin
		if (iSprite.alpha != '0)
			mergeRgb = {iSprite.red, iSprite.green, iSprite.blue};
		else if (iBack.alpha != '0)
			mergeRgb = {iBack.red, iBack.green, iBack.blue};
		else
			mergeRgb = '0;
	end

	// Alpha dropped, frame mark from the background
	always_comb
	begin
		{pushPixel.red, pushPixel.green, pushPixel.blue} = mergeRgb;
		pushPixel.frameStart = iBack.frameStart;
	end

	//------------------------------
	// Output FIFO
	//------------------------------
	pixelFifo #(
		.pWidth ($bits(pixelT)),
		.pDepth (`OUT_FIFO_DEPTH)
	) outFifo_inst (
		.iClk  (iClk),
		.reset (reset),
		.iPush (iMerge),
		.iPop  (iPop),
		.iData (pushPixel),
		.oData (headPixel),
		.oFull (oFull),
		.oEmp  (oEmp)
	);

	// Head captured on pop
	always_ff @(posedge iClk)
	begin
		if (iPop)
			oPixel <= headPixel;
	end

	// Valid for the cycle after a pop
	always_ff @(posedge iClk)
	begin
		if (reset)
			oVd <= 1'b0;
		else
			oVd <= iPop;
	end

	// Both layers walk the same raster in lock step
	aFrameAgree : assert property (@(posedge iClk) disable iff (reset)
		iMerge |-> (iBack.frameStart == iSprite.frameStart))
		else $error("Fail %0t: layer frame marks differ", $time);

endmodule

// ==== pixelCtrl.sv ====
//------------------------------
// Pixel pipeline control
// Start-up FSM and step, merge and pop strobes
//------------------------------
`timescale 1ns/1ns

module pixelCtrl
	import pixelGenPkg::*;
(
	input  logic iClk,
	input  logic reset,
	input  logic iEnable,
	input  logic iCke,
	input  logic iBackFull,
	input  logic iSpriteFull,
	input  logic iBackEmp,
	input  logic iSpriteEmp,
	input  logic iOutFull,
	input  logic iOutEmp,
	output logic oStep,
	output logic oMerge,
	output logic oOutPop
);

	ctrlStateT state;
	ctrlStateT nextState;

	//------------------------------
	// State machine
	//------------------------------
	// LOAD gives the size registers one cycle
	always_comb
	begin
		nextState = state;
		unique case (state)
			IDLE:    nextState = iEnable ? LOAD : IDLE;
			LOAD:    nextState = iEnable ? RUN : IDLE;
			RUN:     nextState = iEnable ? RUN : IDLE;
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge iClk)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= nextState;
	end

	//------------------------------
	// Strobes
	//------------------------------
	// Raster only moves while both layers have room
	assign oStep   = (state == RUN) && !iBackFull && !iSpriteFull;
	// Pair of dots in, room for one pixel out
	assign oMerge  = !iBackEmp && !iSpriteEmp && !iOutFull;
	assign oOutPop = iCke && !iOutEmp;

	// Layer FIFOs share push and pop, so their levels track
	aLayerLock : assert property (@(posedge iClk) disable iff (reset)
		(iBackEmp == iSpriteEmp) && (iBackFull == iSpriteFull))
		else $error("Fail %0t: layer FIFO levels diverged", $time);

endmodule

// ==== videoPixelGen.sv ====
//------------------------------
// Video pixel generator top
// Display size registers, control and datapath wiring
//------------------------------
`timescale 1ns/1ns
`include "pixelGen_settings.svh"

module videoPixelGen
	import pixelGenPkg::*;
(
	input  logic                     iClk,
	input  logic                     reset,
	input  logic                     iEnable,
	input  logic                     iCke,
	input  logic [`PIXEL_HWIDTH-1:0] iHdisplay,
	input  logic [`PIXEL_VWIDTH-1:0] iVdisplay,
	input  rectT                     iBackRect,
	input  rectT                     iSpriteRect,
	output pixelT                    oPixel,
	output logic                     oVd
);

	logic [`PIXEL_HWIDTH-1:0] lastCol;
	logic [`PIXEL_VWIDTH-1:0] lastRow;
	logic [`PIXEL_HWIDTH-1:0] hPos;
	logic [`PIXEL_VWIDTH-1:0] vPos;
	logic                     frameStart;
	logic                     step;
	logic                     mergeEn;
	logic                     outPop;
	dotT                      backDot;
	dotT                      spriteDot;
	logic                     backFull;
	logic                     backEmp;
	logic                     spriteFull;
	logic                     spriteEmp;
	logic                     outFull;
	logic                     outEmp;

	// Last column and row, sizes are counts
	always_ff @(posedge iClk)
	begin
		lastCol <= iHdisplay - 1'b1;
		lastRow <= iVdisplay - 1'b1;
	end

	pixelCtrl pixelCtrl_inst (
		.iClk (iClk), .reset (reset), .iEnable (iEnable), .iCke (iCke),
		.iBackFull (backFull), .iSpriteFull (spriteFull),
		.iBackEmp (backEmp), .iSpriteEmp (spriteEmp),
		.iOutFull (outFull), .iOutEmp (outEmp),
		.oStep (step), .oMerge (mergeEn), .oOutPop (outPop)
	);

	drawPosition drawPosition_inst (
		.iClk (iClk), .reset (reset), .iStep (step),
		.iLastCol (lastCol), .iLastRow (lastRow),
		.oHpos (hPos), .oVpos (vPos), .oFrameStart (frameStart)
	);

	// Background below, sprite above
	squareLayer backLayer (
		.iClk (iClk), .reset (reset), .iRect (iBackRect),
		.iHpos (hPos), .iVpos (vPos), .iFrameStart (frameStart),
		.iStep (step), .iPop (mergeEn),
		.oDot (backDot), .oFull (backFull), .oEmp (backEmp)
	);

	squareLayer spriteLayer (
		.iClk (iClk), .reset (reset), .iRect (iSpriteRect),
		.iHpos (hPos), .iVpos (vPos), .iFrameStart (frameStart),
		.iStep (step), .iPop (mergeEn),
		.oDot (spriteDot), .oFull (spriteFull), .oEmp (spriteEmp)
	);

	layerMerge layerMerge_inst (
		.iClk (iClk), .reset (reset), .iBack (backDot), .iSprite (spriteDot),
		.iMerge (mergeEn), .iPop (outPop),
		.oPixel (oPixel), .oVd (oVd), .oFull (outFull), .oEmp (outEmp)
	);

endmodule

// ==== tbVideoPixelGen.sv ====
//------------------------------
// Video pixel generator testbench
// Raster reference model, painter's rule and frame mark checks
// Back-pressure with random clock enable and resize after reset
//------------------------------
`timescale 1ns/1ns
`include "pixelGen_settings.svh"

module tbVideoPixelGen
	import pixelGenPkg::*;
();

	// Three frames of 48 pixels at 20 cycles each plus margin
	localparam int cFramePixels = 48;
	localparam int cWatchdogNs  = 3 * cFramePixels * 20 * 10 + 2000;

	logic                     iClk = 1'b0;
	logic                     reset;
	logic                     iEnable;
	logic                     iCke;
	logic [`PIXEL_HWIDTH-1:0] iHdisplay;
	logic [`PIXEL_VWIDTH-1:0] iVdisplay;
	rectT                     iBackRect;
	rectT                     iSpriteRect;
	pixelT                    oPixel;
	logic                     oVd;

	// Model position of the next expected pixel
	logic [`PIXEL_HWIDTH-1:0] modelCol   = '0;
	logic [`PIXEL_VWIDTH-1:0] modelRow   = '0;
	int                       pixelCount = 0;
	pixelT                    expPixel;
	logic                     quietWindow = 1'b0;
	integer                   seed       = 32'h7d6897b6;

	always #5 iClk = ~iClk;

	videoPixelGen videoPixelGen_inst (
		.iClk        (iClk),
		.reset       (reset),
		.iEnable     (iEnable),
		.iCke        (iCke),
		.iHdisplay   (iHdisplay),
		.iVdisplay   (iVdisplay),
		.iBackRect   (iBackRect),
		.iSpriteRect (iSpriteRect),
		.oPixel      (oPixel),
		.oVd         (oVd)
	);

	//------------------------------
	// Helpers
	//------------------------------
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped");
	endtask

	// Inclusive bounds
	function automatic logic inRect(input rectT r, input logic [`PIXEL_HWIDTH-1:0] col,
		input logic [`PIXEL_VWIDTH-1:0] row);
		return (col >= r.xStart) && (col <= r.xEnd) && (row >= r.yStart) && (row <= r.yEnd);
	endfunction

	// Visible layers as {sprite, background} with transparent ones absent
	function automatic logic [1:0] pixelCase(input logic [`PIXEL_HWIDTH-1:0] col,
		input logic [`PIXEL_VWIDTH-1:0] row, input rectT back, input rectT sprite);
		logic spriteOn;
		logic backOn;
		spriteOn = inRect(sprite, col, row) && (sprite.color[15:12] != 4'h0);
		backOn   = inRect(back, col, row) && (back.color[15:12] != 4'h0);
		return {spriteOn, backOn};
	endfunction

	// Painter's order with alpha dropped and the mark at the origin
	function automatic pixelT expectPixel(input logic [`PIXEL_HWIDTH-1:0] col,
		input logic [`PIXEL_VWIDTH-1:0] row, input rectT back, input rectT sprite);
		pixelT       p;
		logic [1:0]  layers;
		logic [15:0] argb;
		layers = pixelCase(col, row, back, sprite);
		if (layers[1])
			argb = sprite.color;
		else if (layers[0])
			argb = back.color;
		else
			argb = 16'h0000;
		p.red        = argb[11:8];
		p.green      = argb[7:4];
		p.blue       = argb[3:0];
		p.frameStart = (col == '0) && (row == '0);
		return p;
	endfunction

	task automatic waitPixels(input int target);
		while (pixelCount < target)
			@(negedge iClk);
	endtask

	// Drained once oVd has stayed low for several cycles
	task automatic waitDrained();
		int quietCycles;
		quietCycles = 0;
		while (quietCycles < 8)
		begin
			@(negedge iClk);
			if (oVd)
				quietCycles = 0;
			else
				quietCycles++;
		end
	endtask

	//------------------------------
	// Reference model
	//------------------------------
	assign expPixel = expectPixel(modelCol, modelRow, iBackRect, iSpriteRect);

	// Own raster walk with one step per valid pixel
	always @(posedge iClk)
	begin
		if (reset)
		begin
			modelCol <= '0;
			modelRow <= '0;
		end
		else if (oVd)
		begin
			pixelCount <= pixelCount + 1;
			if (modelCol == iHdisplay - 1'b1)
			begin
				modelCol <= '0;
				modelRow <= (modelRow == iVdisplay - 1'b1) ? '0 : modelRow + 1'b1;
			end
			else
				modelCol <= modelCol + 1'b1;
		end
	end

	//------------------------------
	// Checks
	//------------------------------
	aQuiet : assert property (@(posedge iClk) quietWindow |-> !oVd)
		else abortRun($sformatf("Fail %0t: oVd high while idle or in reset", $time));

	aPixelColor : assert property (@(posedge iClk)
		oVd |-> ({oPixel.red, oPixel.green, oPixel.blue} ==
		{expPixel.red, expPixel.green, expPixel.blue}))
		else abortRun($sformatf("Fail %0t: pixel %0d color %h, expected %h", $time,
			pixelCount, $sampled(oPixel), $sampled(expPixel)));

	aFrameMark : assert property (@(posedge iClk)
		oVd |-> (oPixel.frameStart == expPixel.frameStart))
		else abortRun($sformatf("Fail %0t: pixel %0d frame mark %b, expected %b", $time,
			pixelCount, $sampled(oPixel.frameStart), $sampled(expPixel.frameStart)));

	// A valid pixel needs a pop and a pop needs iCke
	aCkeBeforeValid : assert property (@(posedge iClk) disable iff (reset)
		oVd |-> $past(iCke))
		else abortRun($sformatf("Fail %0t: oVd without iCke in the cycle before", $time));

	// Watchdog
	initial
	begin
		#(cWatchdogNs);
		abortRun("Watchdog expired: the DUT stopped delivering pixels");
	end

	//------------------------------
	// Stimulus
	//------------------------------
	initial
	begin
		integer rnd;
		int     base;
		reset       = 1'b1;
		iEnable     = 1'b0;
		iCke        = 1'b0;
		iHdisplay   = 11'd8;
		iVdisplay   = 11'd6;
		iBackRect   = '{xStart: 11'd1, xEnd: 11'd5, yStart: 11'd1, yEnd: 11'd4, color: 16'hFA50};
		iSpriteRect = '{xStart: 11'd4, xEnd: 11'd7, yStart: 11'd3, yEnd: 11'd5, color: 16'h80C3};
		@(posedge iClk);
		@(negedge iClk);
		quietWindow = 1'b1;
		repeat (9) @(negedge iClk);
		reset = 1'b0;
		// Nothing may come out while enable is low
		iCke = 1'b1;
		repeat (8) @(negedge iClk);
		quietWindow = 1'b0;
		iEnable = 1'b1;
		// One frame with iCke held high
		waitPixels(cFramePixels);
		// One more frame under back-pressure
		while (pixelCount < 2 * cFramePixels)
		begin
			@(negedge iClk);
			rnd  = $random(seed);
			iCke = rnd[0];
		end
		@(negedge iClk);
		iCke    = 1'b1;
		iEnable = 1'b0;
		waitDrained();
		quietWindow = 1'b1;
		repeat (8) @(negedge iClk);
		// Resize to 5 by 4 with new squares during reset
		reset       = 1'b1;
		iHdisplay   = 11'd5;
		iVdisplay   = 11'd4;
		iBackRect   = '{xStart: 11'd0, xEnd: 11'd2, yStart: 11'd0, yEnd: 11'd1, color: 16'h1123};
		iSpriteRect = '{xStart: 11'd2, xEnd: 11'd4, yStart: 11'd1, yEnd: 11'd3, color: 16'hF3F6};
		repeat (10) @(negedge iClk);
		reset = 1'b0;
		repeat (4) @(negedge iClk);
		quietWindow = 1'b0;
		base        = pixelCount;
		iEnable     = 1'b1;
		// Two frames on the new raster
		waitPixels(base + 2 * 20);
		repeat (4) @(negedge iClk);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== videoPixelGen.f ====
+incdir+.
pixelGenPkg.sv
pixelFifo.sv
drawPosition.sv
squareLayer.sv
layerMerge.sv
pixelCtrl.sv
videoPixelGen.sv
tbVideoPixelGen.sv

// ==== Makefile ====
# Verilator simulation of the video pixel generator
TOP := tbVideoPixelGen

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# Exit status of the simulation is the test result
test:
	verilator --binary --timing --assert -f videoPixelGen.f --top-module $(TOP) -o simTop
	./obj_dir/simTop

clean:
	rm -rf obj_dir
